/* design/rx_const_pkg.sv */
package rx_const_pkg;

    // adc slice magnitude and slice count
    localparam int Nadc = 8;
    localparam int Nti = 16;

    // unfolded code carries the sign as an extra bit
    localparam int Ncode = Nadc + 1;

    // phase interpolator control
    localparam int Npi = 9;
    localparam int Nout = 4;

    // averaging window is 2^navg samples
    localparam int Navg_w = 4;

    // prbs checker
    localparam int Ncnt = 32;
    localparam int Nprbs = 7;

endpackage

/* design/rx_ctrl_pkg.sv */
package rx_ctrl_pkg;

    // prbs checker operating mode
    typedef enum logic [1:0] {
        PRBS_CLEAR = 2'd0,
        PRBS_ALIGN = 2'd1,
        PRBS_CHECK = 2'd2,
        PRBS_HOLD  = 2'd3
    } prbs_mode_t;

    // checker input source
    typedef enum logic {
        SRC_SLICER = 1'b0,
        SRC_SIGN   = 1'b1
    } bit_src_t;

endpackage

/* design/pfd_cal_if.sv */
`timescale 1ns/1ps

interface pfd_cal_if #(
    parameter int n_slices   = rx_const_pkg::Nti,
    parameter int code_width = rx_const_pkg::Ncode
) ();

    logic                           en_pfd_cal;
    logic                           en_ext_offset;
    logic signed [code_width-1:0]   ext_offset [n_slices-1:0];
    logic [rx_const_pkg::Navg_w-1:0] navg;

    // calibrated offsets read back by the top
    logic signed [code_width-1:0]   pfd_offset [n_slices-1:0];

    modport ctrl (output en_pfd_cal, en_ext_offset, ext_offset, navg, input pfd_offset);
    modport unit (input en_pfd_cal, en_ext_offset, ext_offset, navg, output pfd_offset);

endinterface

/* design/prbs_dbg_if.sv */
`timescale 1ns/1ps

interface prbs_dbg_if #(
    parameter int cnt_width = rx_const_pkg::Ncnt
) ();

    rx_ctrl_pkg::prbs_mode_t mode;

    // bit counters and lock status
    logic [cnt_width-1:0] correct_bits;
    logic [cnt_width-1:0] total_bits;
    logic                 aligned;

    modport ctrl (
        output mode,
        input  correct_bits, total_bits, aligned
    );

    // checker side reports counts and lock
    modport chk (
        input  mode,
        output correct_bits, total_bits, aligned
    );

endinterface

/* design/adc_retimer.sv */
`timescale 1ns/1ps

module adc_retimer #(
    parameter int n_slices  = rx_const_pkg::Nti,
    parameter int adc_width = rx_const_pkg::Nadc
) (
    input  logic                 clk_adc_i,
    input  logic                 arst_n_i,
    input  logic [adc_width-1:0] data_i [n_slices-1:0],
    input  logic [n_slices-1:0]  sign_i,
    input  logic [n_slices-1:0]  mux_ctrl_i,
    output logic [adc_width-1:0] data_o [n_slices-1:0],
    output logic [n_slices-1:0]  sign_o
);

    logic [adc_width-1:0] data_q1 [n_slices-1:0];
    logic [adc_width-1:0] data_q2 [n_slices-1:0];
    logic [n_slices-1:0]  sign_q1;
    logic [n_slices-1:0]  sign_q2;

    always_ff @(posedge clk_adc_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < n_slices; i++) begin
                data_q1[i] <= '0;
                data_q2[i] <= '0;
            end
            sign_q1 <= '0;
            sign_q2 <= '0;
        end else begin
            data_q1 <= data_i;
            data_q2 <= data_q1;
            sign_q1 <= sign_i;
            sign_q2 <= sign_q1;
        end
    end

    // late-phase slices take the second stage
    for (genvar i = 0; i < n_slices; i++) begin : g_slice
        assign data_o[i] = mux_ctrl_i[i] ? data_q2[i] : data_q1[i];
        assign sign_o[i] = mux_ctrl_i[i] ? sign_q2[i] : sign_q1[i];

        known_out_a: assert property (@(posedge clk_adc_i) disable iff (!arst_n_i)
            !$isunknown({sign_o[i], data_o[i]}))
        else $error("retimer slice %0d output unknown", i);
    end

endmodule

/* design/adc_unfolding.sv */
`timescale 1ns/1ps

module adc_unfolding #(
    parameter  int n_slices   = rx_const_pkg::Nti,
    parameter  int adc_width  = rx_const_pkg::Nadc,
    localparam int code_width = adc_width + 1
) (
    input  logic                         clk_adc_i,
    input  logic                         arst_n_i,
    input  logic [adc_width-1:0]         data_i [n_slices-1:0],
    input  logic [n_slices-1:0]          sign_i,
    pfd_cal_if.unit                      cal,
    output logic signed [code_width-1:0] code_o [n_slices-1:0]
);

    // largest navg shift and the matching accumulator headroom
    localparam int max_shift = (1 << rx_const_pkg::Navg_w) - 1;
    localparam int acc_width = code_width + max_shift;

    logic signed [code_width-1:0] raw_code [n_slices-1:0];
    logic signed [code_width-1:0] offset [n_slices-1:0];
    logic signed [acc_width-1:0]  acc_sum [n_slices-1:0];
    logic signed [acc_width-1:0]  acc_q [n_slices-1:0];
    logic signed [code_width-1:0] pfd_offset_q [n_slices-1:0];
    logic [max_shift-1:0]         sample_cnt_q;
    logic                         last_sample;

    always_comb begin
        for (int i = 0; i < n_slices; i++) begin
            // sign 1 means positive
            raw_code[i] = sign_i[i] ? $signed({1'b0, data_i[i]})
                                    : -$signed({1'b0, data_i[i]});
            offset[i] = cal.en_ext_offset ? cal.ext_offset[i] : pfd_offset_q[i];
            acc_sum[i] = acc_q[i] + raw_code[i];
        end
    end

    // window holds 2^navg samples
    assign last_sample = (sample_cnt_q == max_shift'((32'd1 << cal.navg) - 32'd1));

    always_ff @(posedge clk_adc_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sample_cnt_q <= '0;
            for (int i = 0; i < n_slices; i++) begin
                acc_q[i]        <= '0;
                pfd_offset_q[i] <= '0;
                code_o[i]       <= '0;
            end
        end else begin
            for (int i = 0; i < n_slices; i++) begin
                code_o[i] <= raw_code[i] - offset[i];
            end

            if (cal.en_pfd_cal) begin
                if (last_sample) begin
                    // arithmetic shift floors toward minus infinity
                    sample_cnt_q <= '0;
                    for (int i = 0; i < n_slices; i++) begin
                        acc_q[i]        <= '0;
                        pfd_offset_q[i] <= code_width'(acc_sum[i] >>> cal.navg);
                    end
                end else begin
                    sample_cnt_q <= sample_cnt_q + 1'b1;
                    for (int i = 0; i < n_slices; i++) begin
                        acc_q[i] <= acc_sum[i];
                    end
                end
            end else begin
                // offsets hold, next window starts clean
                sample_cnt_q <= '0;
                for (int i = 0; i < n_slices; i++) begin
                    acc_q[i] <= '0;
                end
            end
        end
    end

    assign cal.pfd_offset = pfd_offset_q;

    navg_stable_a: assert property (@(posedge clk_adc_i) disable iff (!arst_n_i)
        cal.en_pfd_cal |=> !cal.en_pfd_cal || $stable(cal.navg))
    else $error("navg changed during offset calibration");

endmodule

/* design/bit_slicer.sv */
`timescale 1ns/1ps

module bit_slicer #(
    parameter int n_slices   = rx_const_pkg::Nti,
    parameter int code_width = rx_const_pkg::Ncode
) (
    input  logic                         clk_adc_i,
    input  logic                         arst_n_i,
    input  logic signed [code_width-1:0] code_i [n_slices-1:0],
    input  logic signed [code_width-1:0] thresh_i,
    output logic [n_slices-1:0]          bit_o
);

    always_ff @(posedge clk_adc_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            bit_o <= '0;
        end else begin
            // strictly above threshold decides a one
            for (int i = 0; i < n_slices; i++) begin
                bit_o[i] <= (code_i[i] > thresh_i);
            end
        end
    end

endmodule

/* design/prbs_checker.sv */
`timescale 1ns/1ps

module prbs_checker #(
    parameter int n_slices  = rx_const_pkg::Nti,
    parameter int cnt_width = rx_const_pkg::Ncnt
) (
    input  logic                clk_adc_i,
    input  logic                arst_n_i,
    input  logic [n_slices-1:0] rx_bits_i,
    prbs_dbg_if.chk             dbg
);

    localparam int n_prbs      = rx_const_pkg::Nprbs;
    localparam int match_width = $clog2(n_slices + 1);

    if (n_slices < n_prbs) begin : g_width_check
        $error("prbs_checker needs at least %0d slices", n_prbs);
    end

    // state_q[0] is the most recent bit
    logic [n_prbs-1:0]          state_q;
    logic [n_prbs-1:0]          rx_state;
    logic [n_prbs+n_slices-1:0] seq;
    logic [n_slices-1:0]        pred;
    logic [match_width-1:0]     n_match;
    logic [cnt_width-1:0]       correct_q;
    logic [cnt_width-1:0]       total_q;
    logic                       aligned_q;

    always_comb begin
        // oldest bit first, then extend with x^7+x^6+1
        seq = '0;
        for (int j = 0; j < n_prbs; j++) begin
            seq[j] = state_q[n_prbs-1-j];
        end
        for (int i = 0; i < n_slices; i++) begin
            seq[n_prbs+i] = seq[i+1] ^ seq[i];
        end
        pred = seq[n_prbs +: n_slices];

        n_match = '0;
        for (int i = 0; i < n_slices; i++) begin
            n_match = n_match + match_width'(pred[i] == rx_bits_i[i]);
        end

        // last bits of the word, newest in bit 0
        for (int k = 0; k < n_prbs; k++) begin
            rx_state[k] = rx_bits_i[n_slices-1-k];
        end
    end

    always_ff @(posedge clk_adc_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q   <= '0;
            correct_q <= '0;
            total_q   <= '0;
            aligned_q <= 1'b0;
        end else begin
            case (dbg.mode)
                rx_ctrl_pkg::PRBS_CLEAR: begin
                    state_q   <= '0;
                    correct_q <= '0;
                    total_q   <= '0;
                    aligned_q <= 1'b0;
                end
                rx_ctrl_pkg::PRBS_ALIGN: begin
                    state_q   <= rx_state;
                    aligned_q <= 1'b1;
                end
                rx_ctrl_pkg::PRBS_CHECK: begin
                    // resync from received bits so one error stays local
                    state_q   <= rx_state;
                    correct_q <= correct_q + cnt_width'(n_match);
                    total_q   <= total_q + cnt_width'(n_slices);
                end
                default: begin
                    // hold
                    state_q <= state_q;
                end
            endcase
        end
    end

    assign dbg.correct_bits = correct_q;
    assign dbg.total_bits   = total_q;
    assign dbg.aligned      = aligned_q;

    count_order_a: assert property (@(posedge clk_adc_i) disable iff (!arst_n_i)
        dbg.correct_bits <= dbg.total_bits)
    else $error("correct bit count above total count");

endmodule

/* design/pi_ctl_scaler.sv */
`timescale 1ns/1ps

module pi_ctl_scaler #(
    parameter  int n_out     = rx_const_pkg::Nout,
    parameter  int pi_width  = rx_const_pkg::Npi,
    localparam int sel_width = pi_width - 4
) (
    input  logic                 clk_adc_i,
    input  logic                 arst_n_i,
    input  logic [pi_width-1:0]  pi_ctl_i [n_out-1:0],
    input  logic [pi_width-1:0]  pi_offset_i [n_out-1:0],
    input  logic [sel_width-1:0] max_sel_i [n_out-1:0],
    input  logic [n_out-1:0]     bypass_en_i,
    input  logic [pi_width-1:0]  bypass_val_i [n_out-1:0],
    output logic [pi_width-1:0]  pi_ctl_o [n_out-1:0]
);

    logic [pi_width-1:0]   unscaled [n_out-1:0];
    logic [pi_width-1:0]   scale [n_out-1:0];
    logic [2*pi_width-1:0] product [n_out-1:0];

    always_comb begin
        for (int j = 0; j < n_out; j++) begin
            // offset add wraps at pi_width
            unscaled[j] = pi_ctl_i[j] + pi_offset_i[j];
            // (max_sel+1)*16-1 is max_sel with four ones appended
            scale[j]    = {max_sel_i[j], 4'hf};
            product[j]  = unscaled[j] * scale[j];
        end
    end

    always_ff @(posedge clk_adc_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int j = 0; j < n_out; j++) begin
                pi_ctl_o[j] <= '0;
            end
        end else begin
            for (int j = 0; j < n_out; j++) begin
                pi_ctl_o[j] <= bypass_en_i[j] ? bypass_val_i[j]
                                              : product[j][2*pi_width-1:pi_width];
            end
        end
    end

endmodule

/* design/rx_digital_core.sv */
`timescale 1ns/1ps

module rx_digital_core #(
    parameter  int n_slices   = rx_const_pkg::Nti,
    parameter  int adc_width  = rx_const_pkg::Nadc,
    parameter  int pi_width   = rx_const_pkg::Npi,
    localparam int code_width = adc_width + 1,
    localparam int n_out      = rx_const_pkg::Nout,
    localparam int sel_width  = pi_width - 4,
    localparam int cnt_width  = rx_const_pkg::Ncnt
) (
    input  logic                            clk_adc_i,
    input  logic                            arst_n_i,
    // adc slices
    input  logic [adc_width-1:0]            adc_data_i [n_slices-1:0],
    input  logic [n_slices-1:0]             adc_sign_i,
    input  logic [n_slices-1:0]             mux_ctrl_i,
    // offset calibration
    input  logic                            en_pfd_cal_i,
    input  logic                            en_ext_offset_i,
    input  logic signed [code_width-1:0]    ext_offset_i [n_slices-1:0],
    input  logic [rx_const_pkg::Navg_w-1:0] navg_i,
    output logic signed [code_width-1:0]    pfd_offset_o [n_slices-1:0],
    output logic signed [code_width-1:0]    adc_code_o [n_slices-1:0],
    // bit decision and prbs
    input  logic signed [code_width-1:0]    thresh_i,
    input  rx_ctrl_pkg::bit_src_t           bit_src_i,
    input  rx_ctrl_pkg::prbs_mode_t         prbs_mode_i,
    output logic [cnt_width-1:0]            prbs_correct_o,
    output logic [cnt_width-1:0]            prbs_total_o,
    output logic                            prbs_aligned_o,
    // interpolator control
    input  logic [pi_width-1:0]             pi_ctl_i [n_out-1:0],
    input  logic [pi_width-1:0]             pi_offset_i [n_out-1:0],
    input  logic [sel_width-1:0]            max_sel_i [n_out-1:0],
    input  logic [n_out-1:0]                bypass_en_i,
    input  logic [pi_width-1:0]             bypass_val_i [n_out-1:0],
    output logic [pi_width-1:0]             pi_ctl_o [n_out-1:0]
);

    pfd_cal_if #(.n_slices(n_slices), .code_width(code_width)) cal_if ();
    prbs_dbg_if #(.cnt_width(cnt_width)) prbs_if ();

    logic [adc_width-1:0]         data_rt [n_slices-1:0];
    logic [n_slices-1:0]          sign_rt;
    logic signed [code_width-1:0] codes [n_slices-1:0];
    logic [n_slices-1:0]          slice_bits;
    logic [n_slices-1:0]          sign_q;
    logic [n_slices-1:0]          rx_bits;
    rx_ctrl_pkg::bit_src_t        bit_src_q;

    // calibration controls
    assign cal_if.en_pfd_cal    = en_pfd_cal_i;
    assign cal_if.en_ext_offset = en_ext_offset_i;
    assign cal_if.ext_offset    = ext_offset_i;
    assign cal_if.navg          = navg_i;
    assign pfd_offset_o         = cal_if.pfd_offset;

    adc_retimer #(.n_slices(n_slices), .adc_width(adc_width)) retimer_i (
        .clk_adc_i  (clk_adc_i),
        .arst_n_i   (arst_n_i),
        .data_i     (adc_data_i),
        .sign_i     (adc_sign_i),
        .mux_ctrl_i (mux_ctrl_i),
        .data_o     (data_rt),
        .sign_o     (sign_rt)
    );

    adc_unfolding #(.n_slices(n_slices), .adc_width(adc_width)) unfold_i (
        .clk_adc_i (clk_adc_i),
        .arst_n_i  (arst_n_i),
        .data_i    (data_rt),
        .sign_i    (sign_rt),
        .cal       (cal_if.unit),
        .code_o    (codes)
    );

    assign adc_code_o = codes;

    bit_slicer #(.n_slices(n_slices), .code_width(code_width)) slicer_i (
        .clk_adc_i (clk_adc_i),
        .arst_n_i  (arst_n_i),
        .code_i    (codes),
        .thresh_i  (thresh_i),
        .bit_o     (slice_bits)
    );

    // sign path gets one stage, so it lands a cycle ahead of the slicer path
    always_ff @(posedge clk_adc_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sign_q    <= '0;
            bit_src_q <= rx_ctrl_pkg::SRC_SLICER;
        end else begin
            sign_q    <= sign_rt;
            bit_src_q <= bit_src_i;
        end
    end

    assign rx_bits = (bit_src_q == rx_ctrl_pkg::SRC_SIGN) ? sign_q : slice_bits;

    assign prbs_if.mode    = prbs_mode_i;
    assign prbs_correct_o  = prbs_if.correct_bits;
    assign prbs_total_o    = prbs_if.total_bits;
    assign prbs_aligned_o  = prbs_if.aligned;

    prbs_checker #(.n_slices(n_slices), .cnt_width(cnt_width)) prbs_i (
        .clk_adc_i (clk_adc_i),
        .arst_n_i  (arst_n_i),
        .rx_bits_i (rx_bits),
        .dbg       (prbs_if.chk)
    );

    pi_ctl_scaler #(.n_out(n_out), .pi_width(pi_width)) pi_scale_i (
        .clk_adc_i    (clk_adc_i),
        .arst_n_i     (arst_n_i),
        .pi_ctl_i     (pi_ctl_i),
        .pi_offset_i  (pi_offset_i),
        .max_sel_i    (max_sel_i),
        .bypass_en_i  (bypass_en_i),
        .bypass_val_i (bypass_val_i),
        .pi_ctl_o     (pi_ctl_o)
    );

endmodule

/* bench/clk_rst_gen.sv */
`timescale 1ns/1ps

module clk_rst_gen #(
    parameter int period_ns  = 10,
    parameter int rst_cycles = 10
) (
    output logic clk_o,
    output logic arst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(period_ns / 2.0) clk_o = ~clk_o;
        end
    end

    // reset released on a rising edge
    initial begin
        arst_n_o = 1'b0;
        repeat (rst_cycles) @(posedge clk_o);
        arst_n_o <= 1'b1;
    end

endmodule

/* bench/tb_rx_digital_core.sv */
`timescale 1ns/1ps

module tb_rx_digital_core;

    localparam int n_sl       = rx_const_pkg::Nti;
    localparam int adc_w      = rx_const_pkg::Nadc;
    localparam int code_w     = rx_const_pkg::Ncode;
    localparam int pi_w       = rx_const_pkg::Npi;
    localparam int sel_w      = rx_const_pkg::Npi - 4;
    localparam int n_out      = rx_const_pkg::Nout;
    localparam int navg_w     = rx_const_pkg::Navg_w;
    localparam int cnt_w      = rx_const_pkg::Ncnt;
    localparam int clk_period = 10;
    localparam int rst_cycles = 10;
    localparam int n_tests    = 6;
    localparam int n_pi       = 6;

    // test table with name, two arguments and cycle budget
    string test_name [n_tests] = '{"unfold_ext_offset", "retimer_align", "offset_cal",
                                   "prbs_sign", "prbs_slicer_flips", "pi_scaling"};
    int test_arg_a [n_tests]  = '{8, 5, 3, 20, 24, 0};
    int test_arg_b [n_tests]  = '{0, 0, 0, 0, 3, 0};
    int test_cycles [n_tests] = '{20, 15, 25, 40, 45, 15};

    // interpolator vectors with expected outputs
    int pi_ctl_tab [n_pi]  = '{100, 500, 256, 511, 300, 42};
    int pi_off_tab [n_pi]  = '{0, 20, 0, 1, 100, 7};
    int pi_sel_tab [n_pi]  = '{31, 15, 7, 31, 0, 3};
    int pi_byp_tab [n_pi]  = '{0, 0, 0, 0, 0, 1};
    int pi_bval_tab [n_pi] = '{0, 0, 0, 0, 0, 'h155};
    int pi_exp_tab [n_pi]  = '{99, 3, 63, 0, 11, 'h155};

    logic                      clk;
    logic                      arst_n;
    logic [adc_w-1:0]          adc_data [n_sl-1:0];
    logic [n_sl-1:0]           adc_sign;
    logic [n_sl-1:0]           mux_ctrl;
    logic                      en_pfd_cal;
    logic                      en_ext_offset;
    logic signed [code_w-1:0]  ext_offset [n_sl-1:0];
    logic [navg_w-1:0]         navg;
    logic signed [code_w-1:0]  pfd_offset [n_sl-1:0];
    logic signed [code_w-1:0]  adc_code [n_sl-1:0];
    logic signed [code_w-1:0]  thresh;
    rx_ctrl_pkg::bit_src_t     bit_src;
    rx_ctrl_pkg::prbs_mode_t   prbs_mode;
    logic [cnt_w-1:0]          prbs_correct;
    logic [cnt_w-1:0]          prbs_total;
    logic                      prbs_aligned;
    logic [pi_w-1:0]           pi_ctl [n_out-1:0];
    logic [pi_w-1:0]           pi_offset [n_out-1:0];
    logic [sel_w-1:0]          max_sel [n_out-1:0];
    logic [n_out-1:0]          bypass_en;
    logic [pi_w-1:0]           bypass_val [n_out-1:0];
    logic [pi_w-1:0]           pi_ctl_out [n_out-1:0];

    integer     seed = 32'hc7fd095e;
    logic [6:0] prbs_hist = 7'h5a;
    int         n_checks = 0;
    int         n_errors = 0;
    int         n_bad_tests = 0;

    clk_rst_gen #(.period_ns(clk_period), .rst_cycles(rst_cycles)) clk_gen (
        .clk_o    (clk),
        .arst_n_o (arst_n)
    );

    rx_digital_core dut0 (
        .clk_adc_i       (clk),
        .arst_n_i        (arst_n),
        .adc_data_i      (adc_data),
        .adc_sign_i      (adc_sign),
        .mux_ctrl_i      (mux_ctrl),
        .en_pfd_cal_i    (en_pfd_cal),
        .en_ext_offset_i (en_ext_offset),
        .ext_offset_i    (ext_offset),
        .navg_i          (navg),
        .pfd_offset_o    (pfd_offset),
        .adc_code_o      (adc_code),
        .thresh_i        (thresh),
        .bit_src_i       (bit_src),
        .prbs_mode_i     (prbs_mode),
        .prbs_correct_o  (prbs_correct),
        .prbs_total_o    (prbs_total),
        .prbs_aligned_o  (prbs_aligned),
        .pi_ctl_i        (pi_ctl),
        .pi_offset_i     (pi_offset),
        .max_sel_i       (max_sel),
        .bypass_en_i     (bypass_en),
        .bypass_val_i    (bypass_val),
        .pi_ctl_o        (pi_ctl_out)
    );

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        n_checks++;
        if (actual !== expected) begin
            n_errors++;
            $display("FAIL %s: got %h, expected %h", name, actual, expected);
        end
    endtask

    // reference prbs7 with bit 0 of the word earliest
    task automatic next_prbs_word(output logic [n_sl-1:0] word);
        logic nb;
        for (int i = 0; i < n_sl; i++) begin
            nb = prbs_hist[5] ^ prbs_hist[6];
            word[i] = nb;
            prbs_hist = {prbs_hist[5:0], nb};
        end
    endtask

    task automatic drive_unfold_vectors(input int n_vec);
        int exp_q [$];
        int off_val [n_sl];
        int mag;
        int sgn;
        @(posedge clk);
        en_ext_offset <= 1'b1;
        mux_ctrl      <= '0;
        for (int i = 0; i < n_sl; i++) begin
            off_val[i] = $random(seed) % 16;
            ext_offset[i] <= code_w'(off_val[i]);
        end
        // new vector every cycle and the code lags by two
        for (int n = 0; n < n_vec + 2; n++) begin
            @(posedge clk);
            if (n < n_vec) begin
                for (int i = 0; i < n_sl; i++) begin
                    mag = $unsigned($random(seed)) % 240;
                    sgn = $random(seed) & 1;
                    adc_data[i] <= adc_w'(mag);
                    adc_sign[i] <= sgn[0];
                    exp_q.push_back((sgn == 1 ? mag : -mag) - off_val[i]);
                end
            end
            @(negedge clk);
            if (n >= 2) begin
                for (int i = 0; i < n_sl; i++) begin
                    check_value($sformatf("adc_code_o[%0d]", i), 32'(adc_code[i]),
                                exp_q.pop_front());
                end
            end
        end
    endtask

    task automatic check_retimer_skew(input int s);
        int exp_v;
        @(posedge clk);
        mux_ctrl      <= n_sl'(1) << s;
        en_ext_offset <= 1'b1;
        adc_sign      <= '1;
        for (int i = 0; i < n_sl; i++) begin
            ext_offset[i] <= '0;
        end
        // ramp on all slices where the delayed slice trails by one step
        for (int n = 0; n < 8; n++) begin
            @(posedge clk);
            for (int i = 0; i < n_sl; i++) begin
                adc_data[i] <= adc_w'(n + 1);
            end
            @(negedge clk);
            if (n >= 3) begin
                for (int i = 0; i < n_sl; i++) begin
                    exp_v = (i == s) ? n - 2 : n - 1;
                    check_value($sformatf("adc_code_o[%0d]", i), 32'(adc_code[i]), exp_v);
                end
            end
        end
    endtask

    task automatic calibrate_offsets(input int nv);
        int cval [n_sl];
        @(posedge clk);
        mux_ctrl      <= '0;
        en_ext_offset <= 1'b0;
        navg          <= navg_w'(nv);
        for (int i = 0; i < n_sl; i++) begin
            cval[i] = (i % 2 == 1) ? 3 * i + 5 : -(3 * i + 5);
            adc_data[i] <= adc_w'(3 * i + 5);
            adc_sign[i] <= (i % 2 == 1);
        end
        // constant has to reach the unfolding stage first
        repeat (3) @(posedge clk);
        en_pfd_cal <= 1'b1;
        repeat ((1 << nv) - 1) @(posedge clk);
        // one sample short of the window the offsets still read zero
        @(negedge clk);
        for (int i = 0; i < n_sl; i++) begin
            check_value($sformatf("pfd_offset_o[%0d]", i), 32'(pfd_offset[i]), 0);
        end
        @(posedge clk);
        en_pfd_cal <= 1'b0;
        @(negedge clk);
        for (int i = 0; i < n_sl; i++) begin
            check_value($sformatf("pfd_offset_o[%0d]", i), 32'(pfd_offset[i]), cval[i]);
        end
        @(posedge clk);
        @(negedge clk);
        for (int i = 0; i < n_sl; i++) begin
            check_value($sformatf("adc_code_o[%0d]", i), 32'(adc_code[i]), 0);
        end
    endtask

    task automatic count_prbs_bits(input rx_ctrl_pkg::bit_src_t src, input int n_check,
                                   input int n_flips);
        logic [n_sl-1:0] word;
        logic [n_sl-1:0] flip;
        int              spacing;
        spacing = (n_check - 4) / (n_flips + 1);
        @(posedge clk);
        bit_src       <= src;
        // the path that is not selected sees a pattern that breaks the count
        thresh        <= (src == rx_ctrl_pkg::SRC_SIGN) ? code_w'(-128) : code_w'(0);
        en_ext_offset <= 1'b1;
        mux_ctrl      <= '0;
        adc_sign      <= '1;
        for (int i = 0; i < n_sl; i++) begin
            ext_offset[i] <= '0;
            adc_data[i]   <= adc_w'(64);
        end
        for (int c = -6; c < n_check + 3; c++) begin
            @(posedge clk);
            next_prbs_word(word);
            flip = '0;
            // flips stay in the first nine bits so the checker state is clean
            if (n_flips > 0 && c > 0 && c % spacing == 0 && c / spacing <= n_flips) begin
                flip[(c / spacing) % 9] = 1'b1;
            end
            if (src == rx_ctrl_pkg::SRC_SIGN) begin
                adc_sign <= word ^ flip;
            end else begin
                // prbs rides on the magnitude and the sign stays positive
                for (int i = 0; i < n_sl; i++) begin
                    adc_data[i] <= (word[i] ^ flip[i]) ? adc_w'(64) : adc_w'(0);
                end
            end
            if (c < -1) begin
                prbs_mode <= rx_ctrl_pkg::PRBS_CLEAR;
            end else if (c == -1) begin
                prbs_mode <= rx_ctrl_pkg::PRBS_ALIGN;
            end else if (c < n_check) begin
                prbs_mode <= rx_ctrl_pkg::PRBS_CHECK;
            end else begin
                prbs_mode <= rx_ctrl_pkg::PRBS_HOLD;
            end
        end
        @(negedge clk);
        check_value("prbs_total_o", prbs_total, n_sl * n_check);
        check_value("prbs_correct_o", prbs_correct, n_sl * n_check - n_flips);
        check_value("prbs_aligned_o", 32'(prbs_aligned), 1);
    endtask

    task automatic sweep_pi_table();
        int idx;
        // output j takes row r+j and a new row comes every cycle
        for (int r = 0; r <= n_pi; r++) begin
            @(posedge clk);
            if (r < n_pi) begin
                for (int j = 0; j < n_out; j++) begin
                    idx = (r + j) % n_pi;
                    pi_ctl[j]     <= pi_w'(pi_ctl_tab[idx]);
                    pi_offset[j]  <= pi_w'(pi_off_tab[idx]);
                    max_sel[j]    <= sel_w'(pi_sel_tab[idx]);
                    bypass_val[j] <= pi_w'(pi_bval_tab[idx]);
                    bypass_en[j]  <= (pi_byp_tab[idx] != 0);
                end
            end
            @(negedge clk);
            if (r > 0) begin
                for (int j = 0; j < n_out; j++) begin
                    idx = (r - 1 + j) % n_pi;
                    check_value($sformatf("pi_ctl_o[%0d]", j), 32'(pi_ctl_out[j]),
                                pi_exp_tab[idx]);
                end
            end
        end
    endtask

    initial begin
        int err_before;
        int chk_before;
        adc_sign      = '0;
        mux_ctrl      = '0;
        en_pfd_cal    = 1'b0;
        en_ext_offset = 1'b0;
        navg          = '0;
        thresh        = '0;
        bit_src       = rx_ctrl_pkg::SRC_SLICER;
        prbs_mode     = rx_ctrl_pkg::PRBS_CLEAR;
        bypass_en     = '0;
        for (int i = 0; i < n_sl; i++) begin
            adc_data[i]   = '0;
            ext_offset[i] = '0;
        end
        for (int j = 0; j < n_out; j++) begin
            pi_ctl[j]     = '0;
            pi_offset[j]  = '0;
            max_sel[j]    = '0;
            bypass_val[j] = '0;
        end
        @(posedge arst_n);
        repeat (2) @(posedge clk);
        for (int t = 0; t < n_tests; t++) begin
            err_before = n_errors;
            chk_before = n_checks;
            case (t)
                0: drive_unfold_vectors(test_arg_a[t]);
                1: check_retimer_skew(test_arg_a[t]);
                2: calibrate_offsets(test_arg_a[t]);
                3: count_prbs_bits(rx_ctrl_pkg::SRC_SIGN, test_arg_a[t], test_arg_b[t]);
                4: count_prbs_bits(rx_ctrl_pkg::SRC_SLICER, test_arg_a[t], test_arg_b[t]);
                default: sweep_pi_table();
            endcase
            if (n_errors != err_before) begin
                n_bad_tests++;
            end
            $display("test %0d %s: %0d checks, %0d mismatches", t + 1, test_name[t],
                     n_checks - chk_before, n_errors - err_before);
        end
        $display("summary: %0d tests, %0d with mismatches, %0d checks, %0d mismatches",
                 n_tests, n_bad_tests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // watchdog sized from the test table
    initial begin : watchdog
        int budget;
        budget = rst_cycles + 50;
        for (int t = 0; t < n_tests; t++) begin
            budget += test_cycles[t];
        end
        #(budget * clk_period);
        $display("watchdog: run did not finish within %0d clock cycles", budget);
        $display("tests failed");
        $finish;
    end

endmodule

/* vlog.f */
design/rx_const_pkg.sv
design/rx_ctrl_pkg.sv
design/pfd_cal_if.sv
design/prbs_dbg_if.sv
design/adc_retimer.sv
design/adc_unfolding.sv
design/bit_slicer.sv
design/prbs_checker.sv
design/pi_ctl_scaler.sv
design/rx_digital_core.sv
bench/clk_rst_gen.sv
bench/tb_rx_digital_core.sv
